// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_top
FILELIST  = files.f
OBJDIR    = obj_dir
SIM       = $(OBJDIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)

// ==== files.f ====
src/cache_pkg.sv
src/cache.sv
src/bus_arbiter.sv
src/main_memory.sv
src/mem_subsystem.sv
sim/check_monitor.sv
sim/tb_top.sv

// ==== sim/check_monitor.sv ====
`timescale 1ns/10ps

module check_monitor (
  input  logic                clk,
  input  logic                reset,
  input  cache_pkg::cpu_req_t cpu_a_req,
  input  cache_pkg::cpu_rsp_t cpu_a_rsp,
  input  cache_pkg::cpu_req_t cpu_b_req,
  input  cache_pkg::cpu_rsp_t cpu_b_rsp,
  input  logic [1:0]          fast_hit,
  output int                  error_count,
  output int                  check_count
);

  // memory decodes byte address bits 9:0 only
  logic [7:0]  ref_mem [1024];
  logic [1:0]  busy;
  logic [1:0]  is_read;
  logic [1:0]  want_fast;
  int          waited [2];
  logic [31:0] expected [2];

  initial
  begin
    for (int i = 0; i < 1024; i++)
      ref_mem[i] = 8'(i);
  end

  function automatic logic [31:0] read_ref(input logic [31:0] addr);
    logic [31:0] word;
    for (int k = 0; k < 4; k++)
      word[8*k +: 8] = ref_mem[10'(addr + 32'(k))];
    return word;
  endfunction

  task automatic write_ref(input logic [31:0] addr, input logic [31:0] data);
    for (int k = 0; k < 4; k++)
      ref_mem[10'(addr + 32'(k))] = data[8*k +: 8];
  endtask

  task automatic watch_port(
    input int                  p,
    input string               name,
    input cache_pkg::cpu_req_t req,
    input cache_pkg::cpu_rsp_t rsp,
    input logic                fast
  );
    if (busy[p])
    begin
      waited[p] = waited[p] + 1;
      if (rsp.ready)
      begin
        check_count = check_count + 1;
        if (is_read[p] && rsp.rdata !== expected[p])
        begin
          $display("FAILED at %0t: cpu_%s_rsp.rdata expected %h got %h",
                   $time, name, expected[p], rsp.rdata);
          error_count = error_count + 1;
        end
        if (want_fast[p] && waited[p] != 2)
        begin
          $display("port %s: read hit answered after %0d cycles instead of 2", name, waited[p]);
          error_count = error_count + 1;
        end
        busy[p] = 1'b0;
      end
      else if (waited[p] > 40)
      begin
        $display("port %s: no ready within 40 cycles of the strobe at %0t", name, $time);
        error_count = error_count + 1;
        busy[p] = 1'b0;
      end
    end
    else if (rsp.ready)
    begin
      $display("port %s: ready pulse at %0t without an outstanding access", name, $time);
      error_count = error_count + 1;
    end
    // new access, expected value taken from the reference at the strobe
    if (req.read || req.write)
    begin
      if (req.write)
        write_ref(req.addr, req.wdata);
      busy[p]      = 1'b1;
      is_read[p]   = req.read;
      want_fast[p] = fast;
      waited[p]    = 0;
      expected[p]  = read_ref(req.addr);
    end
  endtask

  always @(posedge clk)
  begin
    if (reset)
    begin
      busy        = '0;
      error_count = 0;
      check_count = 0;
    end
    else
    begin
      watch_port(0, "a", cpu_a_req, cpu_a_rsp, fast_hit[0]);
      watch_port(1, "b", cpu_b_req, cpu_b_rsp, fast_hit[1]);
    end
  end

endmodule

// ==== sim/tb_top.sv ====
`timescale 1ns/10ps

module tb_top;

  typedef enum logic [1:0] {
    op_none,
    op_read,
    op_write
  } op_t;

  typedef struct {
    string       name;
    op_t         op_a;
    op_t         op_b;
    logic [31:0] addr;
    logic [31:0] wdata;
    bit          rnd;
    bit          fast;
  } row_t;

  logic                clk;
  logic                reset;
  cache_pkg::cpu_req_t cpu_a_req;
  cache_pkg::cpu_rsp_t cpu_a_rsp;
  cache_pkg::cpu_req_t cpu_b_req;
  cache_pkg::cpu_rsp_t cpu_b_rsp;
  logic [1:0]          fast_hit;
  int                  error_count;
  int                  check_count;

  row_t rows[$];
  int   cycles;
  int   cycle_limit;
  int   rows_passed;
  int   rows_failed;

  mem_subsystem u_dut (
    .clk       (clk),
    .reset     (reset),
    .cpu_a_req (cpu_a_req),
    .cpu_a_rsp (cpu_a_rsp),
    .cpu_b_req (cpu_b_req),
    .cpu_b_rsp (cpu_b_rsp)
  );

  check_monitor u_check (
    .clk         (clk),
    .reset       (reset),
    .cpu_a_req   (cpu_a_req),
    .cpu_a_rsp   (cpu_a_rsp),
    .cpu_b_req   (cpu_b_req),
    .cpu_b_rsp   (cpu_b_rsp),
    .fast_hit    (fast_hit),
    .error_count (error_count),
    .check_count (check_count)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit)
    begin
      $display("timeout after %0d cycles, the DUT stopped answering", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  function automatic void add_row(string name, op_t op_a, op_t op_b, logic [31:0] addr,
                                  logic [31:0] wdata, bit rnd, bit fast);
    row_t r;
    r.name  = name;
    r.op_a  = op_a;
    r.op_b  = op_b;
    r.addr  = addr;
    r.wdata = wdata;
    r.rnd   = rnd;
    r.fast  = fast;
    rows.push_back(r);
  endfunction

  task automatic build_table();
    add_row("first aligned read", op_read, op_none, 32'h40, 32'h0, 0, 0);
    add_row("repeat read hit", op_read, op_none, 32'h40, 32'h0, 0, 1);
    add_row("offset 1 both miss", op_read, op_none, 32'h49, 32'h0, 0, 0);
    add_row("offset 2 one hit", op_read, op_none, 32'h4e, 32'h0, 0, 0);
    add_row("offset 3 both hit", op_read, op_none, 32'h4b, 32'h0, 0, 0);
    add_row("aligned write", op_write, op_none, 32'h60, 32'h1234_5678, 0, 0);
    add_row("read back aligned", op_read, op_none, 32'h60, 32'h0, 0, 1);
    add_row("offset 1 write", op_write, op_none, 32'h65, 32'h0, 1, 0);
    add_row("read across writes", op_read, op_none, 32'h63, 32'h0, 0, 0);
    add_row("read past write", op_read, op_none, 32'h67, 32'h0, 0, 0);
    add_row("offset 3 write", op_write, op_none, 32'h7f, 32'h0, 1, 0);
    add_row("read back offset 2", op_read, op_none, 32'h7e, 32'h0, 0, 0);
    add_row("write-through aligned", op_none, op_read, 32'h60, 32'h0, 0, 0);
    add_row("write-through split", op_none, op_read, 32'h7d, 32'h0, 0, 0);
    add_row("dual read miss", op_read, op_read, 32'h100, 32'h0, 0, 0);
    add_row("dual split read", op_read, op_read, 32'h10a, 32'h0, 0, 0);
    add_row("dual read hit", op_read, op_read, 32'h108, 32'h0, 0, 1);
    add_row("conflict write", op_write, op_none, 32'h200, 32'h0, 1, 0);
    add_row("conflict other tag", op_read, op_none, 32'h220, 32'h0, 0, 0);
    add_row("conflict refill", op_read, op_none, 32'h200, 32'h0, 0, 0);
    add_row("conflict split write", op_write, op_none, 32'h221, 32'h0, 1, 0);
    add_row("conflict read first", op_read, op_none, 32'h200, 32'h0, 0, 0);
    add_row("conflict read split", op_read, op_none, 32'h222, 32'h0, 0, 0);
    add_row("port b conflict write", op_none, op_write, 32'h300, 32'h0, 1, 0);
    add_row("port b other tag", op_none, op_read, 32'h320, 32'h0, 0, 0);
    add_row("port b refill", op_none, op_read, 32'h300, 32'h0, 0, 0);
  endtask

  task automatic apply_row(input int n);
    row_t        r;
    logic [31:0] data;
    bit          done_a;
    bit          done_b;
    int          errors_before;
    r             = rows[n];
    data          = r.rnd ? $urandom() : r.wdata;
    errors_before = error_count;
    cpu_a_req     = '{read: r.op_a == op_read, write: r.op_a == op_write, addr: r.addr,
                      wdata: data};
    cpu_b_req     = '{read: r.op_b == op_read, write: r.op_b == op_write, addr: r.addr,
                      wdata: data};
    fast_hit      = {r.fast && r.op_b != op_none, r.fast && r.op_a != op_none};
    done_a        = (r.op_a == op_none);
    done_b        = (r.op_b == op_none);
    @(posedge clk);
    #1;
    cpu_a_req.read  = 1'b0;
    cpu_a_req.write = 1'b0;
    cpu_b_req.read  = 1'b0;
    cpu_b_req.write = 1'b0;
    fast_hit        = '0;
    // ready never comes in the cycle right after the strobe
    while (!(done_a && done_b))
    begin
      @(posedge clk);
      #1;
      if (cpu_a_rsp.ready)
        done_a = 1'b1;
      if (cpu_b_rsp.ready)
        done_b = 1'b1;
    end
    // monitor compares on the edge that ends the ready cycle
    @(posedge clk);
    #1;
    if (error_count == errors_before)
      rows_passed = rows_passed + 1;
    else
      rows_failed = rows_failed + 1;
    $display("row %0d %s: %s", n, r.name, (error_count == errors_before) ? "passed" : "failed");
  endtask

  initial
  begin
    void'($urandom(32'hcd73));
    cycles      = 0;
    rows_passed = 0;
    rows_failed = 0;
    reset       = 1'b1;
    cpu_a_req   = '0;
    cpu_b_req   = '0;
    fast_hit    = '0;
    build_table();
    cycle_limit = rows.size() * 40 + 50;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    // idle cycles where ready must stay low
    repeat (3) @(posedge clk);
    #1;
    foreach (rows[i])
      apply_row(i);
    $display("rows passed %0d, rows failed %0d, checks %0d, errors %0d",
             rows_passed, rows_failed, check_count, error_count);
    if (rows_failed == 0 && error_count == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

// ==== src/bus_arbiter.sv ====
`timescale 1ns/10ps

module bus_arbiter (
  input  logic                clk,
  input  logic                reset,
  input  cache_pkg::bus_req_t req_a,
  input  cache_pkg::bus_req_t req_b,
  output cache_pkg::bus_rsp_t rsp_a,
  output cache_pkg::bus_rsp_t rsp_b,
  output cache_pkg::bus_req_t mem_req,
  input  cache_pkg::bus_rsp_t mem_rsp
);

  // port a is 0, port b is 1
  logic busy;
  logic owner;
  logic last_served;
  logic pick;
  logic other_valid;

  // tie goes to the port not served last
  assign pick        = (req_a.valid && req_b.valid) ? ~last_served : req_b.valid;
  assign other_valid = owner ? req_a.valid : req_b.valid;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      busy        <= 1'b0;
      owner       <= 1'b0;
      last_served <= 1'b1;
    end
    else if (busy)
    begin
      // owner still holds valid in its ack cycle, so only the other port may take over
      if (mem_rsp.ack)
      begin
        last_served <= owner;
        if (other_valid)
          owner <= ~owner;
        else
          busy <= 1'b0;
      end
    end
    else if (req_a.valid || req_b.valid)
    begin
      busy  <= 1'b1;
      owner <= pick;
    end
  end

  always_comb
  begin
    mem_req = '0;
    rsp_a   = '0;
    rsp_b   = '0;
    if (busy)
    begin
      mem_req = owner ? req_b : req_a;
      if (owner)
        rsp_b = mem_rsp;
      else
        rsp_a = mem_rsp;
    end
  end

endmodule

// ==== src/cache.sv ====
`timescale 1ns/10ps

module cache (
  input  logic                clk,
  input  logic                reset,
  input  cache_pkg::cpu_req_t cpu_req,
  output cache_pkg::cpu_rsp_t cpu_rsp,
  output cache_pkg::bus_req_t bus_req,
  input  cache_pkg::bus_rsp_t bus_rsp
);

  typedef enum logic [2:0] {
    st_idle,
    st_lookup,
    st_fetch,
    st_write_back,
    st_next_word,
    st_respond
  } state_t;

  state_t state;
  state_t after_word;
  logic   is_write;
  logic   second;

  logic [cache_pkg::LINES-1:0] line_valid;
  logic [31:0]                 line_data [cache_pkg::LINES];
  logic [cache_pkg::TAG_W-1:0] line_tag  [cache_pkg::LINES];

  cache_pkg::cache_addr_t req_addr;
  cache_pkg::cache_addr_t cur_addr;
  logic [31:0]            req_wdata;
  logic [31:0]            result;
  logic [31:0]            wt_data;

  logic [cache_pkg::INDEX_W-1:0] idx;
  logic                          start;
  logic                          hit;
  logic                          split;
  logic                          last_word;
  logic                          word_ready;
  logic                          line_wr;
  logic [31:0]                   word_in;
  logic [31:0]                   merged;

  // cpu byte k lands at word position p = k + off - 4*second
  function automatic logic [31:0] place_read(
    input logic [31:0] acc,
    input logic [31:0] word,
    input logic [1:0]  off,
    input logic        hi
  );
    logic [31:0] res;
    int          k;
    res = acc;
    for (int p = 0; p < 4; p++)
    begin
      k = p + (hi ? 4 : 0) - int'(off);
      if (k >= 0 && k < 4)
        res[8*k +: 8] = word[8*p +: 8];
    end
    return res;
  endfunction

  function automatic logic [31:0] merge_write(
    input logic [31:0] word,
    input logic [31:0] wdata,
    input logic [1:0]  off,
    input logic        hi
  );
    logic [31:0] res;
    int          k;
    res = word;
    for (int p = 0; p < 4; p++)
    begin
      k = p + (hi ? 4 : 0) - int'(off);
      if (k >= 0 && k < 4)
        res[8*p +: 8] = wdata[8*k +: 8];
    end
    return res;
  endfunction

  always_comb
  begin
    // word being worked on, first or second of a split access
    cur_addr.bus.word   = req_addr.bus.word + cache_pkg::WORD_W'(second);
    cur_addr.bus.offset = '0;
    idx        = cur_addr.cache.index;
    start      = (state == st_idle) && (cpu_req.read || cpu_req.write);
    hit        = line_valid[idx] && (line_tag[idx] == cur_addr.cache.tag);
    split      = (req_addr.bus.offset != '0);
    last_word  = !split || second;
    word_in    = (state == st_fetch) ? bus_rsp.rdata : line_data[idx];
    word_ready = ((state == st_lookup) && hit) || ((state == st_fetch) && bus_rsp.ack);
    merged     = merge_write(word_in, req_wdata, req_addr.bus.offset, second);
    // fill on every fetch, update on every write
    line_wr    = word_ready && (is_write || (state == st_fetch));
    if (is_write)
      after_word = st_write_back;
    else if (last_word)
      after_word = st_respond;
    else
      after_word = st_next_word;
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state      <= st_idle;
      is_write   <= 1'b0;
      second     <= 1'b0;
      line_valid <= '0;
    end
    else
    begin
      case (state)
        st_idle:
        begin
          if (start)
          begin
            is_write <= cpu_req.write;
            second   <= 1'b0;
            state    <= st_lookup;
          end
        end
        st_lookup:
        begin
          if (hit)
            state <= after_word;
          else
            state <= st_fetch;
        end
        st_fetch:
        begin
          if (bus_rsp.ack)
          begin
            line_valid[idx] <= 1'b1;
            state           <= after_word;
          end
        end
        st_write_back:
        begin
          if (bus_rsp.ack)
            state <= last_word ? st_respond : st_next_word;
        end
        st_next_word:
        begin
          second <= 1'b1;
          state  <= st_lookup;
        end
        st_respond:
        begin
          state <= st_idle;
        end
        default:
        begin
          state <= st_idle;
        end
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      req_addr  <= cpu_req.addr;
      req_wdata <= cpu_req.wdata;
    end
    if (line_wr)
    begin
      line_data[idx] <= is_write ? merged : word_in;
      line_tag[idx]  <= cur_addr.cache.tag;
    end
    if (word_ready)
    begin
      if (is_write)
        wt_data <= merged;
      else
        result <= place_read(result, word_in, req_addr.bus.offset, second);
    end
  end

  always_comb
  begin
    bus_req.valid = (state == st_fetch) || (state == st_write_back);
    bus_req.write = (state == st_write_back);
    bus_req.addr  = cur_addr.bus.word;
    bus_req.wdata = wt_data;
    cpu_rsp.ready = (state == st_respond);
    cpu_rsp.rdata = result;
  end

endmodule

// ==== src/cache_pkg.sv ====
package cache_pkg;

  // cache geometry
  localparam int LINES     = 8;
  localparam int INDEX_W   = $clog2(LINES);
  localparam int OFFSET_W  = 2;
  localparam int TAG_W     = 32 - INDEX_W - OFFSET_W;
  localparam int WORD_W    = 32 - OFFSET_W;

  // main memory size, decoded from byte address bits 9:2
  localparam int MEM_WORDS = 256;
  localparam int MEM_AW    = $clog2(MEM_WORDS);

  typedef struct packed {
    logic [TAG_W-1:0]    tag;
    logic [INDEX_W-1:0]  index;
    logic [OFFSET_W-1:0] offset;
  } cache_view_t;

  typedef struct packed {
    logic [WORD_W-1:0]   word;
    logic [OFFSET_W-1:0] offset;
  } bus_view_t;

  // one byte address, seen as a line lookup or as a word address
  typedef union packed {
    cache_view_t cache;
    bus_view_t   bus;
  } cache_addr_t;

  typedef struct packed {
    logic        read;
    logic        write;
    logic [31:0] addr;
    logic [31:0] wdata;
  } cpu_req_t;

  typedef struct packed {
    logic        ready;
    logic [31:0] rdata;
  } cpu_rsp_t;

  typedef struct packed {
    logic              valid;
    logic              write;
    logic [WORD_W-1:0] addr;
    logic [31:0]       wdata;
  } bus_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] rdata;
  } bus_rsp_t;

endpackage

// ==== src/main_memory.sv ====
`timescale 1ns/10ps

module main_memory (
  input  logic                clk,
  input  logic                reset,
  input  cache_pkg::bus_req_t req,
  output cache_pkg::bus_rsp_t rsp
);

  logic [31:0]                  mem [cache_pkg::MEM_WORDS];
  logic [cache_pkg::MEM_AW-1:0] word_sel;
  logic [31:0]                  rdata;
  logic                         ack;
  logic                         take;

  // upper word address bits ignored
  assign word_sel = req.addr[cache_pkg::MEM_AW-1:0];
  // request still held during its ack cycle is not taken again
  assign take     = req.valid && !ack;

  // every byte starts as the low byte of its own address
  initial
  begin
    for (int w = 0; w < cache_pkg::MEM_WORDS; w++)
    begin
      for (int b = 0; b < 4; b++)
        mem[w][8*b +: 8] = 8'(4 * w + b);
    end
  end

  always @(posedge clk)
  begin
    if (take)
    begin
      if (req.write)
        mem[word_sel] <= req.wdata;
      else
        rdata <= mem[word_sel];
    end
  end

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
      ack <= 1'b0;
    else
      ack <= take;
  end

  assign rsp.ack   = ack;
  assign rsp.rdata = rdata;

endmodule

// ==== src/mem_subsystem.sv ====
`timescale 1ns/10ps

module mem_subsystem (
  input  logic                clk,
  input  logic                reset,
  input  cache_pkg::cpu_req_t cpu_a_req,
  output cache_pkg::cpu_rsp_t cpu_a_rsp,
  input  cache_pkg::cpu_req_t cpu_b_req,
  output cache_pkg::cpu_rsp_t cpu_b_rsp
);

  cache_pkg::bus_req_t bus_a_req;
  cache_pkg::bus_rsp_t bus_a_rsp;
  cache_pkg::bus_req_t bus_b_req;
  cache_pkg::bus_rsp_t bus_b_rsp;
  cache_pkg::bus_req_t mem_req;
  cache_pkg::bus_rsp_t mem_rsp;

  // instruction side
  cache u_cache_a (
    .clk     (clk),
    .reset   (reset),
    .cpu_req (cpu_a_req),
    .cpu_rsp (cpu_a_rsp),
    .bus_req (bus_a_req),
    .bus_rsp (bus_a_rsp)
  );

  // data side
  cache u_cache_b (
    .clk     (clk),
    .reset   (reset),
    .cpu_req (cpu_b_req),
    .cpu_rsp (cpu_b_rsp),
    .bus_req (bus_b_req),
    .bus_rsp (bus_b_rsp)
  );

  bus_arbiter u_bus_arbiter (
    .clk     (clk),
    .reset   (reset),
    .req_a   (bus_a_req),
    .req_b   (bus_b_req),
    .rsp_a   (bus_a_rsp),
    .rsp_b   (bus_b_rsp),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
  );

  main_memory u_main_memory (
    .clk   (clk),
    .reset (reset),
    .req   (mem_req),
    .rsp   (mem_rsp)
  );

endmodule
